// ==== compile.f ====
hdl/mtx_pkg.sv
hdl/mtx_master_sel.sv
hdl/mtx_addr_decode.sv
hdl/mtx_dphase_track.sv
hdl/mtx_matrix_top.sv
testbench/mtx_matrix_checker.sv
testbench/tb_mtx_matrix.sv

// ==== hdl/mtx_addr_decode.sv ====
// Address decode for PPB routing, default memory attributes, HPROT, HSIZE and HTRANS
`timescale 1ns/1ps

module mtx_addr_decode import mtx_pkg::*; #(
   parameter region_t PPB_REGION = PPB_REGION_DEF // Top nibble of the PPB
) (
   input  addr_t      ahb_addr_i,   // Selected address
   input  size_t      ahb_size_i,   // Selected size
   input  logic       ahb_priv_i,   // Selected privilege
   input  logic       ahb_dni_i,    // Selected data not fetch
   input  logic       cpu_trans_i,  // Core transfer, fetch-to-PPB already removed
   input  logic       dif_aphase_i, // Debug address phase
   input  logic       dsl_acc_ok_i, // Debug access permitted

   output logic [1:0] htrans_o,     // AHB HTRANS
   output prot_t      hprot_o,      // AHB HPROT
   output logic [2:0] hsize_o,      // AHB HSIZE
   output logic       shareable_o,  // Shareable attribute
   output logic       ppb_trans_o   // Transfer targets the PPB
);

   // --------------------------------------
   // Default memory map
   // --------------------------------------

   // Attributes from the top three address bits with no MPU
   // PPB space is strongly ordered, but it never reaches AHB
   function automatic scb_t dflt_scb(input logic [2:0] top3);
      scb_t scb;
      case (top3)
         3'd0:    scb = SCB_WT;   // Code
         3'd1:    scb = SCB_WBWA; // SRAM
         3'd2:    scb = SCB_DEV;  // Peripheral
         3'd3:    scb = SCB_WBWA; // External RAM, lower
         3'd4:    scb = SCB_WT;   // External RAM, upper
         3'd5:    scb = SCB_SDEV; // Shared device
         default: scb = SCB_DEV;  // External device and system, 6 and 7
      endcase
      return scb;
   endfunction

   scb_t    ahb_scb;    // Looked-up attribute
   region_t addr_rgn;   // Top nibble of the address
   logic    int_sel;    // Address hits the PPB
   logic    int_trans;  // Transfer may use internal space
   logic    ext_trans;  // Transfer may use the external bus

   // --------------------------------------
   // Region routing
   // --------------------------------------

   assign addr_rgn  = ahb_addr_i[31:28];
   assign int_sel   = (addr_rgn == PPB_REGION);

   // Debugger reaches the PPB only when allowed
   assign int_trans = cpu_trans_i | (dif_aphase_i & dsl_acc_ok_i);
   assign ext_trans = cpu_trans_i | dif_aphase_i;

   assign ppb_trans_o = int_trans & int_sel;

   // PPB transfers stay off the external bus
   assign htrans_o = (ext_trans & ~int_sel) ? HTRANS_NONSEQ : HTRANS_IDLE;

   // --------------------------------------
   // Transfer attributes
   // --------------------------------------

   assign ahb_scb     = dflt_scb(ahb_addr_i[31:29]);
   assign hprot_o     = {ahb_scb[1:0], ahb_priv_i, ahb_dni_i}; // C, B, priv, data
   assign shareable_o = ahb_scb[2];

   // Byte, half and word only
   assign hsize_o = {1'b0, ahb_size_i};

endmodule

// ==== hdl/mtx_dphase_track.sv ====
// Data-phase ownership registers, error steering, PPB write-data mask and debug read-data merge
`timescale 1ns/1ps

module mtx_dphase_track import mtx_pkg::*; (
   input  logic  hclk,             // AHB clock
   input  logic  hreset_n,         // Asynchronous reset, active low
   input  logic  hready_i,         // AHB ready, advances the pipeline
   input  logic  hresp_i,          // AHB error response

   // Address-phase view
   input  logic  cpu_trans_i,      // Core transfer this cycle
   input  logic  dif_aphase_i,     // Debug address phase this cycle
   input  logic  ppb_trans_i,      // PPB transfer this cycle
   input  logic  ahb_write_i,      // Selected write not read

   // Data
   input  data_t ahb_wdata_i,      // Merged write data
   input  data_t hrdata_i,         // External read data
   input  data_t scs_rdata_i,      // PPB read data, zero outside its dphase

   output logic  mtx_cpu_resp_o,   // Error to core
   output logic  mtx_dif_resp_o,   // Error to debugger
   output logic  mtx_ppb_active_o, // PPB data phase
   output logic  mtx_ppb_write_o,  // PPB data phase is a write
   output data_t mtx_ppb_wdata_o,  // Masked PPB write data
   output data_t mtx_dif_rdata_o   // Read data for debugger
);

   logic cpu_dphase_q;  // Core owns the data phase
   logic dif_dphase_q;  // Debugger owns the data phase
   logic ppb_active_q;  // Data phase targets the PPB
   logic ppb_write_q;   // PPB data phase writes
   logic ppb_wr_dp;     // PPB write in progress

   // --------------------------------------
   // Data-phase registers
   // --------------------------------------

   // Address phase moves into data phase on hready
   always_ff @(posedge hclk or negedge hreset_n) begin
      if (!hreset_n) begin
         cpu_dphase_q <= 1'b0;
         dif_dphase_q <= 1'b0;
         ppb_active_q <= 1'b0;
         ppb_write_q  <= 1'b0;
      end else if (hready_i) begin // Hold while the slave stalls
         cpu_dphase_q <= cpu_trans_i;
         dif_dphase_q <= dif_aphase_i;
         ppb_active_q <= ppb_trans_i;
         ppb_write_q  <= ppb_trans_i & ahb_write_i;
      end
   end

   // --------------------------------------
   // Error steering
   // --------------------------------------

   // Debug-initiated errors never reach the core, and the reverse
   assign mtx_cpu_resp_o = hresp_i & cpu_dphase_q;
   assign mtx_dif_resp_o = hresp_i & dif_dphase_q;

   // --------------------------------------
   // PPB data path
   // --------------------------------------

   assign mtx_ppb_active_o = ppb_active_q;
   assign mtx_ppb_write_o  = ppb_write_q;

   // PPB writes are rare; keep its data lines quiet otherwise
   assign ppb_wr_dp       = ppb_active_q & ppb_write_q;
   assign mtx_ppb_wdata_o = {32{ppb_wr_dp}} & ahb_wdata_i;

   // Bus read data is ignored during a PPB data phase
   assign mtx_dif_rdata_o = ({32{~ppb_active_q}} & hrdata_i) | scs_rdata_i;

endmodule

// ==== hdl/mtx_master_sel.sv ====
// Address-phase master selection between core and debugger, debug slot and write-data merge
`timescale 1ns/1ps

module mtx_master_sel import mtx_pkg::*; (
   // Core request
   input  logic  cpu_spec_htrans_i, // Core may start a transfer
   input  logic  cpu_dbg_stall_i,   // Core holds the debugger off
   input  addr_t cpu_haddr_i,       // Core address
   input  size_t cpu_hsize_i,       // Core size
   input  logic  cpu_hwrite_i,      // Core write not read
   input  logic  cpu_priv_i,        // Core privileged
   input  logic  cpu_dni_i,         // Core data not fetch
   input  data_t cpu_hwdata_i,      // Core write data, zero outside its dphase

   // Debugger request
   input  logic  dif_spec_trans_i,  // Debugger wants a slot
   input  logic  dif_aphase_i,      // Debugger owns this address phase
   input  addr_t dif_addr_i,        // Debugger address
   input  size_t dif_size_i,        // Debugger size
   input  logic  dif_write_i,       // Debugger write not read
   input  logic  dif_priv_i,        // Debugger privileged
   input  data_t dif_wdata_i,       // Debugger write data, zero outside its dphase

   // Selected address phase
   output addr_t ahb_addr_o,
   output size_t ahb_size_o,
   output logic  ahb_write_o,
   output logic  ahb_priv_o,
   output logic  ahb_dni_o,
   output data_t ahb_wdata_o,
   output logic  spec_htrans_o,     // Speculative HTRANS[1]
   output logic  dif_slot_o         // Slot granted to debugger
);

   // --------------------------------------
   // Debug slot
   // --------------------------------------

   // Debugger only gets cycles the core is not even speculating on
   assign dif_slot_o = dif_spec_trans_i & ~cpu_spec_htrans_i & ~cpu_dbg_stall_i;

   // Early strobe for read-invariant memories
   // May fire without a later HTRANS, which is the rare case
   assign spec_htrans_o = cpu_spec_htrans_i | dif_spec_trans_i;

   // --------------------------------------
   // Address-phase multiplexer
   // --------------------------------------

   assign ahb_addr_o  = dif_aphase_i ? dif_addr_i  : cpu_haddr_i;  // Debug overrides core
   assign ahb_size_o  = dif_aphase_i ? dif_size_i  : cpu_hsize_i;
   assign ahb_write_o = dif_aphase_i ? dif_write_i : cpu_hwrite_i;
   assign ahb_priv_o  = dif_aphase_i ? dif_priv_i  : cpu_priv_i;

   // Debugger accesses are always data
   assign ahb_dni_o   = dif_aphase_i ? 1'b1 : cpu_dni_i;

   // --------------------------------------
   // Write data
   // --------------------------------------

   // Each master drives zero outside its own data phase
   // so a plain OR merges them with no select
   assign ahb_wdata_o = cpu_hwdata_i | dif_wdata_i;

endmodule

// ==== hdl/mtx_matrix_top.sv ====
// Bus matrix top level joining core and debugger onto one AHB-Lite master port
`timescale 1ns/1ps

module mtx_matrix_top import mtx_pkg::*; #(
   parameter region_t PPB_REGION = PPB_REGION_DEF // PPB top nibble
) (
   input  logic       hclk,
   input  logic       hreset_n,

   // Core
   input  logic       cpu_spec_htrans_i,
   input  logic       cpu_dbg_stall_i,
   input  addr_t      cpu_haddr_i,
   input  size_t      cpu_hsize_i,
   input  logic       cpu_hwrite_i,
   input  logic       cpu_priv_i,
   input  logic       cpu_dni_i,
   input  data_t      cpu_hwdata_i,
   input  logic       cpu_trans_i,

   // Debugger
   input  logic       dif_spec_trans_i,
   input  logic       dif_aphase_i,
   input  addr_t      dif_addr_i,
   input  size_t      dif_size_i,
   input  logic       dif_write_i,
   input  logic       dif_priv_i,
   input  data_t      dif_wdata_i,
   input  logic       dsl_acc_ok_i,

   // AHB slave side and PPB
   input  logic       hready_i,
   input  logic       hresp_i,
   input  data_t      hrdata_i,
   input  data_t      scs_rdata_i,

   // AHB-Lite master port
   output addr_t      haddr_o,
   output logic [2:0] hsize_o,
   output logic       hwrite_o,
   output prot_t      hprot_o,
   output logic [1:0] htrans_o,
   output data_t      hwdata_o,
   output logic       hmaster_o,        // 0 core, 1 debugger
   output logic       shareable_o,
   output logic       spec_htrans_o,
   output logic       mtx_dif_slot_o,   // Slot free for debugger

   // Data-phase results
   output logic       mtx_cpu_resp_o,
   output logic       mtx_dif_resp_o,
   output logic       mtx_ppb_active_o,
   output logic       mtx_ppb_write_o,
   output data_t      mtx_ppb_wdata_o,
   output data_t      mtx_dif_rdata_o
);

   // --------------------------------------
   // Stage wires
   // --------------------------------------

   addr_t ahb_addr;
   size_t ahb_size;
   logic  ahb_write;
   logic  ahb_priv;
   logic  ahb_dni;
   data_t ahb_wdata;
   logic  dif_slot;
   logic  ppb_trans;

   assign haddr_o        = ahb_addr;
   assign hwrite_o       = ahb_write;
   assign hwdata_o       = ahb_wdata;
   assign hmaster_o      = dif_slot;  // Slot owner is the bus master
   assign mtx_dif_slot_o = dif_slot;

   // Stage 1, master select
   mtx_master_sel u_master_sel (
      .cpu_spec_htrans_i (cpu_spec_htrans_i), .cpu_dbg_stall_i (cpu_dbg_stall_i),
      .cpu_haddr_i       (cpu_haddr_i),       .cpu_hsize_i     (cpu_hsize_i),
      .cpu_hwrite_i      (cpu_hwrite_i),      .cpu_priv_i      (cpu_priv_i),
      .cpu_dni_i         (cpu_dni_i),         .cpu_hwdata_i    (cpu_hwdata_i),
      .dif_spec_trans_i  (dif_spec_trans_i),  .dif_aphase_i    (dif_aphase_i),
      .dif_addr_i        (dif_addr_i),        .dif_size_i      (dif_size_i),
      .dif_write_i       (dif_write_i),       .dif_priv_i      (dif_priv_i),
      .dif_wdata_i       (dif_wdata_i),
      .ahb_addr_o        (ahb_addr),          .ahb_size_o      (ahb_size),
      .ahb_write_o       (ahb_write),         .ahb_priv_o      (ahb_priv),
      .ahb_dni_o         (ahb_dni),           .ahb_wdata_o     (ahb_wdata),
      .spec_htrans_o     (spec_htrans_o),     .dif_slot_o      (dif_slot)
   );

   // Stage 2, address decode
   mtx_addr_decode #(.PPB_REGION(PPB_REGION)) u_addr_decode (
      .ahb_addr_i   (ahb_addr),     .ahb_size_i   (ahb_size),
      .ahb_priv_i   (ahb_priv),     .ahb_dni_i    (ahb_dni),
      .cpu_trans_i  (cpu_trans_i),  .dif_aphase_i (dif_aphase_i),
      .dsl_acc_ok_i (dsl_acc_ok_i),
      .htrans_o     (htrans_o),     .hprot_o      (hprot_o),
      .hsize_o      (hsize_o),      .shareable_o  (shareable_o),
      .ppb_trans_o  (ppb_trans)
   );

   // Stage 3, data phase
   mtx_dphase_track u_dphase_track (
      .hclk             (hclk),             .hreset_n        (hreset_n),
      .hready_i         (hready_i),         .hresp_i         (hresp_i),
      .cpu_trans_i      (cpu_trans_i),      .dif_aphase_i    (dif_aphase_i),
      .ppb_trans_i      (ppb_trans),        .ahb_write_i     (ahb_write),
      .ahb_wdata_i      (ahb_wdata),        .hrdata_i        (hrdata_i),
      .scs_rdata_i      (scs_rdata_i),
      .mtx_cpu_resp_o   (mtx_cpu_resp_o),   .mtx_dif_resp_o  (mtx_dif_resp_o),
      .mtx_ppb_active_o (mtx_ppb_active_o), .mtx_ppb_write_o (mtx_ppb_write_o),
      .mtx_ppb_wdata_o  (mtx_ppb_wdata_o),  .mtx_dif_rdata_o (mtx_dif_rdata_o)
   );

endmodule

// ==== hdl/mtx_pkg.sv ====
// Bus field types, private peripheral region constant and default memory attribute encodings
package mtx_pkg;

   // --------------------------------------
   // Bus field types
   // --------------------------------------

   typedef logic [31:0] addr_t;   // AHB address
   typedef logic [31:0] data_t;   // Read or write data
   typedef logic [1:0]  size_t;   // 0 byte, 1 half, 2 word
   typedef logic [2:0]  scb_t;    // Shareable, cacheable, bufferable
   typedef logic [3:0]  prot_t;   // Cacheable, bufferable, privileged, data
   typedef logic [3:0]  region_t; // Top address nibble

   // --------------------------------------
   // Address map
   // --------------------------------------

   // Private peripheral bus sits at 0xE0000000 by default
   localparam region_t PPB_REGION_DEF = 4'hE;

   // --------------------------------------
   // Default memory attributes
   // --------------------------------------

   // Bit order is S, C, B
   localparam scb_t SCB_WT   = 3'b010; // Normal, cacheable write-through
   localparam scb_t SCB_WBWA = 3'b011; // Normal, write-back write-allocate
   localparam scb_t SCB_DEV  = 3'b001; // Device, bufferable only
   localparam scb_t SCB_SDEV = 3'b101; // Shareable device

   // HTRANS encodings used by the matrix
   localparam logic [1:0] HTRANS_IDLE   = 2'b00;
   localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

endpackage

// ==== run.sh ====
#!/bin/sh
# Build and run the bus matrix testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mtx_matrix \
   -f compile.f -o sim_mtx

# An assertion stop ends the run early, so the log decides the result
./obj_dir/sim_mtx > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log || ! grep -q "Verification passed" sim.log; then
   echo "Simulation reported failure"
   exit 1
fi
exit 0

// ==== testbench/mtx_matrix_checker.sv ====
// Protocol assertions for the bus matrix top level and their bind into it
`timescale 1ns/1ps

module mtx_matrix_checker import mtx_pkg::*; #(
   parameter region_t PPB_REGION = PPB_REGION_DEF // PPB top nibble, same as the DUT
) (
   input logic       hclk,
   input logic       hreset_n,
   input addr_t      haddr_o,            // Observed AHB address
   input logic [1:0] htrans_o,           // Observed AHB HTRANS
   input logic       hmaster_o,          // Observed bus master
   input logic       cpu_spec_htrans_i   // Core speculation
);

   // --------------------------------------
   // Region rules
   // --------------------------------------

   // PPB traffic is internal, never started on AHB
   a_no_ppb_nonseq : assert property (
      @(posedge hclk) disable iff (!hreset_n)
      (haddr_o[31:28] == PPB_REGION) |-> (htrans_o != HTRANS_NONSEQ))
      else $error("NONSEQ transfer issued for a PPB address");

   // --------------------------------------
   // Master rules
   // --------------------------------------

   // Debugger only gets the bus when the core is not speculating
   a_master_idle_core : assert property (
      @(posedge hclk) disable iff (!hreset_n)
      hmaster_o |-> !cpu_spec_htrans_i)
      else $error("Debugger granted the bus while the core speculates");

endmodule

bind mtx_matrix_top mtx_matrix_checker #(.PPB_REGION(PPB_REGION)) u_checker (
   .hclk              (hclk),
   .hreset_n          (hreset_n),
   .haddr_o           (haddr_o),
   .htrans_o          (htrans_o),
   .hmaster_o         (hmaster_o),
   .cpu_spec_htrans_i (cpu_spec_htrans_i)
);

// ==== testbench/tb_mtx_matrix.sv ====
// Testbench for the bus matrix with clock, reset, seeded stimulus, assertions and test report
`timescale 1ns/1ps

module tb_mtx_matrix;
   import mtx_pkg::*;

   logic hclk = 1'b0, hreset_n = 1'b0;
   logic cpu_spec_htrans_i, cpu_dbg_stall_i, cpu_hwrite_i, cpu_priv_i, cpu_dni_i, cpu_trans_i;
   addr_t cpu_haddr_i, dif_addr_i;
   size_t cpu_hsize_i, dif_size_i;
   data_t cpu_hwdata_i, dif_wdata_i, hrdata_i, scs_rdata_i;
   logic dif_spec_trans_i, dif_aphase_i, dif_write_i, dif_priv_i, dsl_acc_ok_i;
   logic hready_i, hresp_i;
   addr_t haddr_o;
   logic [2:0] hsize_o;
   logic hwrite_o, hmaster_o, shareable_o, spec_htrans_o, mtx_dif_slot_o;
   prot_t hprot_o;
   logic [1:0] htrans_o;
   data_t hwdata_o, mtx_ppb_wdata_o, mtx_dif_rdata_o;
   logic mtx_cpu_resp_o, mtx_dif_resp_o, mtx_ppb_active_o, mtx_ppb_write_o;

   int errors = 0;
   int tests = 0;

   // Attribute table as bit masks indexed by the top three address bits
   localparam logic [7:0] C_TAB = 8'b0001_1011;
   localparam logic [7:0] B_TAB = 8'b1110_1110;
   localparam logic [7:0] S_TAB = 8'b0010_0000;

   mtx_matrix_top #(.PPB_REGION(4'hE)) u_dut (.*);

   always #4 hclk = ~hclk; // 8 ns period

   // --------------------------------------
   // Reference model of the data phase
   // --------------------------------------

   addr_t sel_addr;
   data_t exp_wdata;
   logic  exp_ppb, exp_wr, exp_slot;
   logic  m_cpu, m_dif, m_ppb, m_ppbw; // Expected data-phase owners

   assign sel_addr  = dif_aphase_i ? dif_addr_i : cpu_haddr_i;
   assign exp_wr    = dif_aphase_i ? dif_write_i : cpu_hwrite_i;
   assign exp_ppb   = (cpu_trans_i | (dif_aphase_i & dsl_acc_ok_i)) & (sel_addr[31:28] == 4'hE);
   assign exp_wdata = cpu_hwdata_i | dif_wdata_i; // Idle master drives zero
   // Debugger wins only a slot the core leaves alone
   assign exp_slot  = (cpu_spec_htrans_i || cpu_dbg_stall_i) ? 1'b0 : dif_spec_trans_i;

   always @(posedge hclk or negedge hreset_n) begin
      if (!hreset_n) begin
         {m_cpu, m_dif, m_ppb, m_ppbw} <= 4'b0;
      end else if (hready_i) begin
         {m_cpu, m_dif, m_ppb, m_ppbw} <= {cpu_trans_i, dif_aphase_i, exp_ppb, exp_ppb & exp_wr};
      end
   end

   // --------------------------------------
   // Checking assertions
   // --------------------------------------

   a_attr : assert property (@(posedge hclk) disable iff (!hreset_n)
      hprot_o[3:2] == {C_TAB[sel_addr[31:29]], B_TAB[sel_addr[31:29]]}
      && shareable_o == S_TAB[sel_addr[31:29]])
      else begin errors++; $display("Fail %0t: attributes wrong for %h", $time, sel_addr); end
   a_route : assert property (@(posedge hclk) disable iff (!hreset_n)
      htrans_o == (((cpu_trans_i | dif_aphase_i) && sel_addr[31:28] != 4'hE) ? 2'b10 : 2'b00))
      else begin errors++; $display("Fail %0t: HTRANS %b wrong", $time, htrans_o); end
   a_ppb_dp : assert property (@(posedge hclk) disable iff (!hreset_n)
      mtx_ppb_active_o == m_ppb && mtx_ppb_write_o == m_ppbw)
      else begin errors++; $display("Fail %0t: PPB data-phase flags wrong", $time); end
   a_hold : assert property (@(posedge hclk) disable iff (!hreset_n)
      !hready_i |=> $stable(mtx_ppb_active_o) && $stable(mtx_ppb_write_o))
      else begin errors++; $display("Fail %0t: PPB flags moved under wait state", $time); end
   a_dif_sel : assert property (@(posedge hclk) disable iff (!hreset_n)
      dif_aphase_i |-> haddr_o == dif_addr_i && hsize_o == {1'b0, dif_size_i}
      && hwrite_o == dif_write_i && hprot_o[1:0] == {dif_priv_i, 1'b1})
      else begin errors++; $display("Fail %0t: debug fields not selected", $time); end
   a_cpu_sel : assert property (@(posedge hclk) disable iff (!hreset_n)
      !dif_aphase_i |-> haddr_o == cpu_haddr_i && hsize_o == {1'b0, cpu_hsize_i}
      && hwrite_o == cpu_hwrite_i && hprot_o[1:0] == {cpu_priv_i, cpu_dni_i})
      else begin errors++; $display("Fail %0t: core fields not selected", $time); end
   a_master : assert property (@(posedge hclk) disable iff (!hreset_n)
      hmaster_o == exp_slot && mtx_dif_slot_o == exp_slot)
      else begin errors++; $display("Fail %0t: hmaster_o %b wrong", $time, hmaster_o); end
   a_spec : assert property (@(posedge hclk) disable iff (!hreset_n)
      spec_htrans_o == (cpu_spec_htrans_i || dif_spec_trans_i))
      else begin errors++; $display("Fail %0t: spec_htrans_o %b", $time, spec_htrans_o); end
   a_resp : assert property (@(posedge hclk)
      mtx_cpu_resp_o == (m_cpu ? hresp_i : 1'b0) && mtx_dif_resp_o == (m_dif ? hresp_i : 1'b0))
      else begin errors++; $display("Fail %0t: error response misrouted", $time); end
   a_wdata : assert property (@(posedge hclk) disable iff (!hreset_n)
      hwdata_o == exp_wdata)
      else begin errors++; $display("Fail %0t: hwdata_o %h", $time, hwdata_o); end
   a_wmask : assert property (@(posedge hclk)
      mtx_ppb_wdata_o == (m_ppbw ? exp_wdata : 32'h0))
      else begin errors++; $display("Fail %0t: PPB wdata %h", $time, mtx_ppb_wdata_o); end
   a_rdata : assert property (@(posedge hclk) disable iff (!hreset_n)
      mtx_dif_rdata_o == (m_ppb ? scs_rdata_i : hrdata_i))
      else begin errors++; $display("Fail %0t: debug rdata %h", $time, mtx_dif_rdata_o); end

   // --------------------------------------
   // Stimulus helpers
   // --------------------------------------

   task automatic next_cycle();
      @(posedge hclk);
      #1;
   endtask

   task automatic idle_bus();
      {cpu_trans_i, dif_aphase_i, cpu_spec_htrans_i, dif_spec_trans_i} = 4'b0;
      {cpu_hwdata_i, dif_wdata_i, scs_rdata_i} = '0;
      {hresp_i, dsl_acc_ok_i} = 2'b0;
      hready_i = 1'b1;
   endtask

   // Polls the PPB active flag, gives up after max_cyc cycles
   task automatic wait_ppb_active(input int max_cyc);
      int n;
      n = 0;
      while (!mtx_ppb_active_o) begin
         if (n == max_cyc) begin
            $display("Timed out waiting for a PPB data phase");
            $display("Verification failed");
            $finish;
         end else begin
            n++;
            next_cycle();
         end
      end
   endtask

   task automatic end_test(input string name);
      tests++;
      $display("Test %0d %s done, errors so far %0d", tests, name, errors);
   endtask

   initial begin
      #100us; // Watchdog over the whole run
      $display("Simulation timed out");
      $display("Verification failed");
      $finish;
   end

   initial begin
      void'($urandom(32'haece5db7));
      idle_bus();
      {cpu_dbg_stall_i, cpu_hwrite_i, cpu_priv_i, cpu_dni_i} = 4'b0;
      {dif_write_i, dif_priv_i} = 2'b0;
      {cpu_haddr_i, dif_addr_i, hrdata_i, cpu_hsize_i, dif_size_i} = '0;
      repeat (5) @(posedge hclk);
      #1 hreset_n = 1'b1;

      // Attribute lookup over random external addresses
      cpu_trans_i = 1'b1;
      repeat (40) begin
         cpu_haddr_i = $urandom;
         if (cpu_haddr_i[31:28] == 4'hE) cpu_haddr_i[28] = 1'b0;
         cpu_priv_i   = 1'($urandom);
         cpu_dni_i    = 1'($urandom);
         cpu_hwrite_i = 1'($urandom);
         cpu_hsize_i  = 2'($urandom_range(0, 2));
         next_cycle();
      end
      cpu_hwrite_i = 1'b0;
      end_test("attributes");

      // PPB against external routing
      cpu_haddr_i = 32'hE000_ED00;
      next_cycle();
      idle_bus();
      wait_ppb_active(4);
      cpu_trans_i = 1'b1;
      cpu_haddr_i = 32'h2000_0040;
      next_cycle();
      idle_bus();
      dif_aphase_i = 1'b1; // Debug PPB access not allowed
      dif_addr_i   = 32'hE000_EDF0;
      next_cycle();
      idle_bus();
      dif_aphase_i = 1'b1; // Same access, now allowed
      dsl_acc_ok_i = 1'b1;
      dif_addr_i   = 32'hE000_EDF0;
      next_cycle();
      idle_bus();
      wait_ppb_active(4);
      next_cycle();
      end_test("routing");

      // Debugger overrides the core address phase
      repeat (40) begin
         {cpu_spec_htrans_i, cpu_dbg_stall_i, dif_spec_trans_i} = 3'($urandom);
         {dif_aphase_i, dif_write_i, dif_priv_i, cpu_trans_i} = 4'($urandom);
         dif_addr_i  = {4'h6, 28'($urandom)};
         dif_size_i  = 2'($urandom_range(0, 2));
         cpu_haddr_i = {4'h1, 28'($urandom)};
         next_cycle();
      end
      idle_bus();
      end_test("debug override");

      // Error responses follow the data-phase owner
      cpu_trans_i = 1'b1;
      next_cycle();
      idle_bus();
      hresp_i = 1'b1;
      next_cycle();
      idle_bus();
      dif_aphase_i = 1'b1;
      dif_addr_i   = 32'h4000_0000;
      next_cycle();
      idle_bus();
      hresp_i     = 1'b1;
      dif_wdata_i = 32'h3C3C_00FF; // Debugger data phase
      next_cycle();
      idle_bus();
      end_test("error steering");

      // PPB write masking under back-pressure
      cpu_trans_i  = 1'b1;
      cpu_hwrite_i = 1'b1;
      cpu_haddr_i  = 32'hE000_E100;
      next_cycle();
      idle_bus();
      cpu_hwdata_i = 32'hA5A5_0F0F;
      cpu_trans_i  = 1'b1;
      cpu_haddr_i  = 32'h0000_0100;
      hready_i     = 1'b0;
      repeat (3) next_cycle();
      hready_i = 1'b1;
      next_cycle();
      cpu_hwrite_i = 1'b0;
      idle_bus();
      cpu_hwdata_i = 32'h1234_5678; // Not a PPB data phase
      next_cycle();
      idle_bus();
      end_test("PPB write mask");

      // Debug read data merge
      repeat (20) begin
         cpu_trans_i = 1'b1;
         cpu_haddr_i = ($urandom_range(0, 1) != 0) ? 32'hE000_E010 : 32'h3000_0010;
         hrdata_i    = $urandom;
         scs_rdata_i = m_ppb ? 32'($urandom) : 32'h0; // SCS answers only its own dphase
         next_cycle();
      end
      idle_bus();
      next_cycle();
      end_test("debug read data");

      $display("Tests %0d, errors %0d", tests, errors);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule
